//--- src/rs_macros.svh
/* Reservation station sizes */

`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// operand and result width.
`define XLEN     32

// number of station slots and the width of a slot index.
`define RS_SIZE  8
`define SLOT_W   3

`define PREG_W   6
`define ROB_W    5

// a credit count must hold the value RS_SIZE itself.
`define CREDIT_W 4

`endif

//--- src/rs_pkg.sv
/* Reservation station types */

`include "rs_macros.svh"

package rs_pkg;

    // integer operations handled by the local ALU.
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5,
        OP_SLL = 3'd6,
        OP_SRL = 3'd7
    } alu_op_e;

    // a source operand is either a value or a tag that is still waiting.
    typedef struct packed {
        logic               ready;
        logic [`PREG_W-1:0] tag;
        logic [`XLEN-1:0]   value;
    } operand_t;

    // one station entry.
    // The operand fields only mean something while busy is set.
    typedef struct packed {
        logic               busy;
        logic [`ROB_W-1:0]  rob;
        logic [`PREG_W-1:0] dest;
        alu_op_e            op;
        operand_t           src1;
        operand_t           src2;
    } rs_slot_t;

endpackage

//--- src/prio_enc.sv
/* Lowest-first priority encoder */

module prio_enc #(
    parameter int SIZE = 8
) (
    input  logic [SIZE-1:0]         req,
    output logic [$clog2(SIZE)-1:0] idx,
    output logic                    none
);

    localparam int IDX_W = $clog2(SIZE);

    // scanning from the top lets the lowest set bit win.
    always_comb begin
        idx = '0;
        for (int i = SIZE - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = IDX_W'(i);
            end
        end
    end

    // idx is zero and meaningless when nothing is requested.
    assign none = ~|req;

endmodule

//--- src/issue_if.sv
/* Station to ALU issue */

`include "rs_macros.svh"

interface issue_if import rs_pkg::*; ();

    logic               valid;
    logic [`ROB_W-1:0]  rob;
    logic [`PREG_W-1:0] dest;
    alu_op_e            op;
    logic [`XLEN-1:0]   src_a;
    logic [`XLEN-1:0]   src_b;

    // the ALU never stalls, so a valid cycle is always a transfer.
    modport station (
        output valid, rob, dest, op, src_a, src_b
    );

    modport alu (
        input valid, rob, dest, op, src_a, src_b
    );

endinterface

//--- src/wb_if.sv
/* Writeback broadcast */

`include "rs_macros.svh"

interface wb_if ();

    logic               valid;
    logic [`ROB_W-1:0]  rob;
    logic [`PREG_W-1:0] dest;
    logic [`XLEN-1:0]   value;

    modport source (
        output valid, rob, dest, value
    );

    // there is no acknowledge, listeners just snoop.
    modport sink (
        input valid, rob, dest, value
    );

endinterface

//--- src/rs_station.sv
/* Integer reservation station */

`include "rs_macros.svh"

module rs_station import rs_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_valid,
    input  logic [`ROB_W-1:0]  disp_rob,
    input  logic [`PREG_W-1:0] disp_dest,
    input  alu_op_e            disp_op,
    input  operand_t           disp_src1,
    input  operand_t           disp_src2,
    output logic               credit_return,
    issue_if.station           iss,
    wb_if.sink                 local_wb,
    wb_if.sink                 ext_wb
);

    rs_slot_t            slots [`RS_SIZE];
    logic [`RS_SIZE-1:0] free_vec;
    logic [`RS_SIZE-1:0] ready_vec;
    logic [`SLOT_W-1:0]  free_idx;
    logic [`SLOT_W-1:0]  ready_idx;
    logic                free_none;
    logic                ready_none;
    logic                alloc;
    rs_slot_t            sel_slot;

    // a waiting operand takes the value of a broadcast whose tag matches.
    // Both broadcasts never carry the same tag, so the order is arbitrary.
    function automatic operand_t wakeup(operand_t opnd);
        operand_t res;
        res = opnd;
        if (!opnd.ready) begin
            if (local_wb.valid && local_wb.dest == opnd.tag) begin
                res.ready = 1'b1;
                res.value = local_wb.value;
            end else if (ext_wb.valid && ext_wb.dest == opnd.tag) begin
                res.ready = 1'b1;
                res.value = ext_wb.value;
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            free_vec[i]  = !slots[i].busy;
            ready_vec[i] = slots[i].busy && slots[i].src1.ready && slots[i].src2.ready;
        end
    end

    prio_enc #(
        .SIZE(`RS_SIZE)
    ) free_sel (
        .req  (free_vec),
        .idx  (free_idx),
        .none (free_none)
    );

    prio_enc #(
        .SIZE(`RS_SIZE)
    ) ready_sel (
        .req  (ready_vec),
        .idx  (ready_idx),
        .none (ready_none)
    );

    // a request with no free slot breaks the credit protocol and is dropped.
    assign alloc    = disp_valid && !free_none;
    assign sel_slot = slots[ready_idx];

    // allocation and issue never touch the same slot, since one is free
    // and the other busy.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                slots[i].busy <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (slots[i].busy) begin
                    slots[i].src1 <= wakeup(slots[i].src1);
                    slots[i].src2 <= wakeup(slots[i].src2);
                end
            end
            if (!ready_none) begin
                slots[ready_idx].busy <= 1'b0;
            end
            if (alloc) begin
                slots[free_idx] <= '{
                    busy: 1'b1,
                    rob:  disp_rob,
                    dest: disp_dest,
                    op:   disp_op,
                    src1: wakeup(disp_src1),
                    src2: wakeup(disp_src2)
                };
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= !ready_none;
        end
    end

    always_ff @(posedge clk) begin
        if (!ready_none) begin
            iss.rob   <= sel_slot.rob;
            iss.dest  <= sel_slot.dest;
            iss.op    <= sel_slot.op;
            iss.src_a <= sel_slot.src1.value;
            iss.src_b <= sel_slot.src2.value;
        end
    end

    // every issue frees exactly one slot, which goes back upstream as a credit.
    assign credit_return = iss.valid;

endmodule

//--- src/exec_unit.sv
/* Pipelined integer ALU */

`include "rs_macros.svh"

module exec_unit import rs_pkg::*; (
    input  logic clk,
    input  logic rst,
    issue_if.alu iss,
    wb_if.source wb
);

    logic               s1_valid;
    logic [`ROB_W-1:0]  s1_rob;
    logic [`PREG_W-1:0] s1_dest;
    alu_op_e            s1_op;
    logic [`XLEN-1:0]   s1_a;
    logic [`XLEN-1:0]   s1_b;
    logic [`XLEN-1:0]   result;

    // stage one only captures the issued micro-op.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= iss.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_rob  <= iss.rob;
        s1_dest <= iss.dest;
        s1_op   <= iss.op;
        s1_a    <= iss.src_a;
        s1_b    <= iss.src_b;
    end

    // shift amounts use the low five bits of the second operand.
    always_comb begin
        case (s1_op)
            OP_ADD:  result = s1_a + s1_b;
            OP_SUB:  result = s1_a - s1_b;
            OP_AND:  result = s1_a & s1_b;
            OP_OR:   result = s1_a | s1_b;
            OP_XOR:  result = s1_a ^ s1_b;
            OP_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(s1_a) < $signed(s1_b)};
            OP_SLL:  result = s1_a << s1_b[4:0];
            OP_SRL:  result = s1_a >> s1_b[4:0];
            default: result = '0;
        endcase
    end

    // stage two puts the result on the local writeback broadcast.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb.rob   <= s1_rob;
        wb.dest  <= s1_dest;
        wb.value <= result;
    end

endmodule

//--- src/rs_subsys.sv
/* Reservation station cluster */

`include "rs_macros.svh"

module rs_subsys import rs_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_valid,
    input  logic [`ROB_W-1:0]  disp_rob,
    input  logic [`PREG_W-1:0] disp_dest,
    input  alu_op_e            disp_op,
    input  logic               disp_src1_ready,
    input  logic [`PREG_W-1:0] disp_src1_tag,
    input  logic [`XLEN-1:0]   disp_src1_value,
    input  logic               disp_src2_ready,
    input  logic [`PREG_W-1:0] disp_src2_tag,
    input  logic [`XLEN-1:0]   disp_src2_value,
    input  logic               ext_wb_valid,
    input  logic [`ROB_W-1:0]  ext_wb_rob,
    input  logic [`PREG_W-1:0] ext_wb_dest,
    input  logic [`XLEN-1:0]   ext_wb_value,
    output logic               credit_return,
    output logic               res_valid,
    output logic [`ROB_W-1:0]  res_rob,
    output logic [`PREG_W-1:0] res_dest,
    output logic [`XLEN-1:0]   res_value
);

    operand_t disp_src1;
    operand_t disp_src2;

    issue_if iss_bus ();
    wb_if    local_wb ();
    wb_if    ext_wb ();

    assign disp_src1 = '{ready: disp_src1_ready, tag: disp_src1_tag, value: disp_src1_value};
    assign disp_src2 = '{ready: disp_src2_ready, tag: disp_src2_tag, value: disp_src2_value};

    // writebacks from the other execution units.
    assign ext_wb.valid = ext_wb_valid;
    assign ext_wb.rob   = ext_wb_rob;
    assign ext_wb.dest  = ext_wb_dest;
    assign ext_wb.value = ext_wb_value;

    rs_station rs_station_i (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_rob      (disp_rob),
        .disp_dest     (disp_dest),
        .disp_op       (disp_op),
        .disp_src1     (disp_src1),
        .disp_src2     (disp_src2),
        .credit_return (credit_return),
        .iss           (iss_bus),
        .local_wb      (local_wb),
        .ext_wb        (ext_wb)
    );

    exec_unit exec_unit_i (
        .clk (clk),
        .rst (rst),
        .iss (iss_bus),
        .wb  (local_wb)
    );

    // the local broadcast doubles as the result bus of the cluster.
    assign res_valid = local_wb.valid;
    assign res_rob   = local_wb.rob;
    assign res_dest  = local_wb.dest;
    assign res_value = local_wb.value;

endmodule

//--- tests/rs_assert.sv
/* Station assertions */

`include "rs_macros.svh"

module rs_assert import rs_pkg::*; (
    input logic               clk,
    input logic               rst,
    input logic               disp_valid,
    input logic               free_none,
    input logic               ready_none,
    input logic [`SLOT_W-1:0] ready_idx,
    input rs_slot_t           slots [`RS_SIZE],
    input logic               iss_valid,
    input logic               wb_valid
);

    int   fail_cnt = 0;
    int   busy_cnt;
    logic sel_ok;

    always_comb begin
        busy_cnt = 0;
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (slots[i].busy) begin
                busy_cnt++;
            end
        end
    end

    assign sel_ok = !ready_none && slots[ready_idx].busy
                    && slots[ready_idx].src1.ready && slots[ready_idx].src2.ready;

    // upstream holds no credit while every slot is taken.
    no_disp_when_full: assert property (@(posedge clk) disable iff (rst)
        disp_valid |-> !free_none)
    else begin
        $error("dispatch while all slots are busy");
        fail_cnt++;
    end

    issue_was_ready: assert property (@(posedge clk) disable iff (rst)
        iss_valid |-> $past(sel_ok))
    else begin
        $error("issued slot did not have both operands ready");
        fail_cnt++;
    end

    // the ALU has a fixed two cycle latency.
    alu_latency: assert property (@(posedge clk) disable iff (rst)
        iss_valid |-> ##2 wb_valid)
    else begin
        $error("issued micro-op missing on local writeback two cycles later");
        fail_cnt++;
    end

    // occupancy moves only by an accepted dispatch or an issue, so it stays within the slots.
    busy_bound: assert property (@(posedge clk) disable iff (rst)
        busy_cnt == $past(busy_cnt) + int'($past(disp_valid && !free_none)) - int'(iss_valid))
    else begin
        $error("busy slot count does not follow accepted dispatches and issues");
        fail_cnt++;
    end

endmodule

bind rs_station rs_assert rs_assert_i (
    .clk        (clk),
    .rst        (rst),
    .disp_valid (disp_valid),
    .free_none  (free_none),
    .ready_none (ready_none),
    .ready_idx  (ready_idx),
    .slots      (slots),
    .iss_valid  (iss.valid),
    .wb_valid   (local_wb.valid)
);

//--- tests/tb_rs_subsys.sv
/* Reservation station testbench */

`include "rs_macros.svh"

module tb_rs_subsys import rs_pkg::*; ();

    typedef logic [`ROB_W-1:0]  rob_t;
    typedef logic [`PREG_W-1:0] preg_t;
    typedef logic [`XLEN-1:0]   word_t;

    localparam int WAIT_LIMIT = 2000;
    localparam int NROB = 2 ** `ROB_W;

    logic     clk;
    logic     rst;
    logic     disp_valid;
    rob_t     disp_rob;
    preg_t    disp_dest;
    alu_op_e  disp_op;
    operand_t disp_src1;
    operand_t disp_src2;
    logic     ext_wb_valid;
    rob_t     ext_wb_rob;
    preg_t    ext_wb_dest;
    word_t    ext_wb_value;
    logic     credit_return;
    logic     res_valid;
    rob_t     res_rob;
    preg_t    res_dest;
    word_t    res_value;

    // scoreboard and operand model, indexed by ROB tag.
    logic     inflight [NROB];
    alu_op_e  m_op [NROB];
    preg_t    m_dest [NROB];
    operand_t m_a [NROB];
    operand_t m_b [NROB];
    int       disp_cyc [NROB];
    int       res_cyc [NROB];

    logic [31:0] lfsr;
    int cyc = 0;
    int credits;
    int returned;
    int outstanding;
    int completed;
    int errors;
    int checks;
    int tests;
    logic hung;

    rs_subsys rs_subsys_i (
        .clk             (clk),
        .rst             (rst),
        .disp_valid      (disp_valid),
        .disp_rob        (disp_rob),
        .disp_dest       (disp_dest),
        .disp_op         (disp_op),
        .disp_src1_ready (disp_src1.ready),
        .disp_src1_tag   (disp_src1.tag),
        .disp_src1_value (disp_src1.value),
        .disp_src2_ready (disp_src2.ready),
        .disp_src2_tag   (disp_src2.tag),
        .disp_src2_value (disp_src2.value),
        .ext_wb_valid    (ext_wb_valid),
        .ext_wb_rob      (ext_wb_rob),
        .ext_wb_dest     (ext_wb_dest),
        .ext_wb_value    (ext_wb_value),
        .credit_return   (credit_return),
        .res_valid       (res_valid),
        .res_rob         (res_rob),
        .res_dest        (res_dest),
        .res_value       (res_value)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR:  return a | b;
            OP_XOR: return a ^ b;
            OP_SLT: begin
                // differing signs decide by the sign of a alone.
                if (a[`XLEN-1] != b[`XLEN-1]) begin
                    return word_t'(a[`XLEN-1]);
                end
                return word_t'(a < b);
            end
            OP_SLL: return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    function automatic operand_t ready_opnd(word_t v);
        return '{ready: 1'b1, tag: '0, value: v};
    endfunction

    function automatic operand_t wait_opnd(preg_t t);
        return '{ready: 1'b0, tag: t, value: 32'hbad0_bad0};
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at time %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_dest(input preg_t got, input preg_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at time %0t: res_dest got %0d expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    // a broadcast of tag t wakes every modeled operand that waits on it.
    task automatic resolve(input preg_t t, input word_t v);
        for (int r = 0; r < NROB; r++) begin
            if (inflight[r] && !m_a[r].ready && m_a[r].tag == t) begin
                m_a[r] = ready_opnd(v);
            end
            if (inflight[r] && !m_b[r].ready && m_b[r].tag == t) begin
                m_b[r] = ready_opnd(v);
            end
        end
    endtask

    task automatic step();
        @(posedge clk);
        disp_valid   <= 1'b0;
        ext_wb_valid <= 1'b0;
    endtask

    task automatic dispatch(input rob_t rob, input preg_t dest, input alu_op_e op,
                            input operand_t a, input operand_t b);
        int n;
        n = 0;
        while ((credits == 0 || inflight[rob]) && !hung) begin
            step();
            n++;
            if (n == WAIT_LIMIT) begin
                $display("Error: no credit or ROB tag %0d still busy after %0d cycles", rob, n);
                hung = 1'b1;
            end
        end
        if (!hung) begin
            disp_valid <= 1'b1;
            disp_rob   <= rob;
            disp_dest  <= dest;
            disp_op    <= op;
            disp_src1  <= a;
            disp_src2  <= b;
            inflight[rob] = 1'b1;
            m_op[rob]     = op;
            m_dest[rob]   = dest;
            m_a[rob]      = a;
            m_b[rob]      = b;
            disp_cyc[rob] = cyc + 1;
            credits--;
            outstanding++;
        end
    endtask

    task automatic broadcast(input preg_t t, input word_t v);
        ext_wb_valid <= 1'b1;
        ext_wb_rob   <= '0;
        ext_wb_dest  <= t;
        ext_wb_value <= v;
        resolve(t, v);
    endtask

    task automatic drain(input logic bcast);
        int n;
        n = 0;
        while (outstanding > 0 && !hung) begin
            step();
            if (bcast) begin
                broadcast(preg_t'(32 + n % 8), rand_bits(32));
            end
            n++;
            if (n == WAIT_LIMIT) begin
                $display("Error: %0d results still missing after %0d cycles", outstanding, n);
                hung = 1'b1;
            end
        end
    endtask

    task automatic report(input string name, input int e0);
        tests++;
        if (errors != e0 || hung) begin
            $display("test %s: failed with %0d errors", name, errors - e0);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    always @(negedge clk) begin : compare
        word_t exp;
        if (!rst && credit_return) begin
            credits++;
            returned++;
        end
        if (!rst && res_valid) begin
            if (!inflight[res_rob]) begin
                $display("Error at time %0t: result for ROB tag %0d that is not outstanding",
                         $time, res_rob);
                errors++;
            end else if (!(m_a[res_rob].ready && m_b[res_rob].ready)) begin
                $display("Error at time %0t: ROB tag %0d completed before its broadcast",
                         $time, res_rob);
                errors++;
                inflight[res_rob] = 1'b0;
                outstanding--;
            end else begin
                exp = alu_ref(m_op[res_rob], m_a[res_rob].value, m_b[res_rob].value);
                check_value("res_value", res_value, exp);
                check_dest(res_dest, m_dest[res_rob]);
                inflight[res_rob] = 1'b0;
                res_cyc[res_rob] = cyc;
                outstanding--;
                completed++;
                resolve(m_dest[res_rob], exp);
            end
        end
    end

    task automatic test_ready_ops();
        int e0;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            step();
            dispatch(rob_t'(i), preg_t'(i), alu_op_e'(i), ready_opnd(rand_bits(32)),
                     ready_opnd(rand_bits(32)));
        end
        drain(1'b0);
        if (!hung && res_cyc[0] - disp_cyc[0] != 4) begin
            $display("Fail at time %0t: first result latency got %0d expected 4",
                     $time, res_cyc[0] - disp_cyc[0]);
            errors++;
        end
        report("ready_operands", e0);
    endtask

    task automatic test_ext_wakeup();
        int e0;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            step();
            if (i % 2 == 0) begin
                dispatch(rob_t'(8 + i), preg_t'(8 + i), alu_op_e'(i + 2),
                         wait_opnd(preg_t'(40 + i)), ready_opnd(rand_bits(32)));
            end else begin
                dispatch(rob_t'(8 + i), preg_t'(8 + i), alu_op_e'(i + 2),
                         ready_opnd(rand_bits(32)), wait_opnd(preg_t'(40 + i)));
            end
        end
        repeat (6) step();
        for (int i = 0; i < 4; i++) begin
            step();
            broadcast(preg_t'(40 + i), rand_bits(32));
        end
        drain(1'b0);
        report("external_wakeup", e0);
    endtask

    task automatic test_chain();
        int e0;
        e0 = errors;
        step();
        dispatch(16, 20, OP_ADD, ready_opnd(rand_bits(32)), ready_opnd(rand_bits(32)));
        step();
        dispatch(17, 21, OP_SUB, wait_opnd(20), ready_opnd(rand_bits(32)));
        step();
        dispatch(18, 22, OP_XOR, ready_opnd(rand_bits(32)), wait_opnd(21));
        drain(1'b0);
        report("local_chain", e0);
    endtask

    task automatic test_alloc_capture();
        int e0;
        e0 = errors;
        step();
        dispatch(12, 23, OP_OR, wait_opnd(50), ready_opnd(rand_bits(32)));
        broadcast(50, rand_bits(32));
        step();
        dispatch(13, 24, OP_SLT, ready_opnd(rand_bits(32)), wait_opnd(51));
        broadcast(51, rand_bits(32));
        drain(1'b0);
        report("capture_at_allocation", e0);
    endtask

    task automatic test_credit_flow();
        int e0;
        int r0;
        e0 = errors;
        r0 = returned;
        for (int i = 0; i < 8; i++) begin
            step();
            dispatch(rob_t'(20 + i), preg_t'(24 + i), alu_op_e'(i),
                     wait_opnd(preg_t'(32 + i)), ready_opnd(rand_bits(32)));
        end
        repeat (6) step();
        if (credits != 0 || returned != r0) begin
            $display("Error at time %0t: %0d credits held and %0d returned with all slots waiting",
                     $time, credits, returned - r0);
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            step();
            broadcast(preg_t'(32 + i), rand_bits(32));
        end
        drain(1'b0);
        if (returned - r0 != 8 || credits != 8) begin
            $display("Error: %0d credits returned and %0d held, expected 8 and 8",
                     returned - r0, credits);
            errors++;
        end
        report("credit_flow", e0);
    endtask

    task automatic test_stress();
        int e0;
        int c0;
        int n;
        int sent;
        rob_t rob;
        operand_t a;
        operand_t b;
        e0 = errors;
        c0 = completed;
        n = 0;
        sent = 0;
        rob = '0;
        while (sent < 200 && !hung) begin
            step();
            if (rand_bits(2) != 0 && credits > 0 && !inflight[rob]) begin
                a = rand_bits(1) ? ready_opnd(rand_bits(32)) : wait_opnd(preg_t'(32 + rand_bits(3)));
                b = rand_bits(1) ? ready_opnd(rand_bits(32)) : wait_opnd(preg_t'(32 + rand_bits(3)));
                dispatch(rob, preg_t'(rand_bits(5)), alu_op_e'(rand_bits(3)), a, b);
                rob++;
                sent++;
            end
            if (rand_bits(1)) begin
                broadcast(preg_t'(32 + rand_bits(3)), rand_bits(32));
            end
            n++;
            if (n == 4 * WAIT_LIMIT) begin
                $display("Error: only %0d of 200 micro-ops dispatched in %0d cycles", sent, n);
                hung = 1'b1;
            end
        end
        drain(1'b1);
        if (completed - c0 != 200 || credits != 8) begin
            $display("Error: %0d of 200 micro-ops completed and %0d credits held",
                     completed - c0, credits);
            errors++;
        end
        report("random_stress", e0);
    endtask

    initial begin
        rst          = 1'b1;
        disp_valid   = 1'b0;
        disp_rob     = '0;
        disp_dest    = '0;
        disp_op      = OP_ADD;
        disp_src1    = '0;
        disp_src2    = '0;
        ext_wb_valid = 1'b0;
        ext_wb_rob   = '0;
        ext_wb_dest  = '0;
        ext_wb_value = '0;
        lfsr         = 32'h177d_3a32;
        credits      = `RS_SIZE;
        returned     = 0;
        outstanding  = 0;
        completed    = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        hung         = 1'b0;
        for (int r = 0; r < NROB; r++) begin
            inflight[r] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        if (!hung) test_ready_ops();
        if (!hung) test_ext_wakeup();
        if (!hung) test_chain();
        if (!hung) test_alloc_capture();
        if (!hung) test_credit_flow();
        if (!hung) test_stress();
        repeat (4) step();
        errors = errors + rs_subsys_i.rs_station_i.rs_assert_i.fail_cnt + int'(hung);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+src
src/rs_pkg.sv
src/prio_enc.sv
src/issue_if.sv
src/wb_if.sv
src/rs_station.sv
src/exec_unit.sv
src/rs_subsys.sv
tests/rs_assert.sv
tests/tb_rs_subsys.sv

//--- Bender.yml
package:
  name: rs_subsys

sources:
  - include_dirs:
      - src
    files:
      - src/rs_pkg.sv
      - src/prio_enc.sv
      - src/issue_if.sv
      - src/wb_if.sv
      - src/rs_station.sv
      - src/exec_unit.sv
      - src/rs_subsys.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/rs_assert.sv
      - tests/tb_rs_subsys.sv
